// ==== include/matmul_config.svh ====
`ifndef MATMUL_CONFIG_SVH
`define MATMUL_CONFIG_SVH

//////////////////////////////
// array and element sizes
//////////////////////////////

// operand and result element width
`define MM_DWIDTH 16
// rows and columns of the array, square matrices
`define MM_DIM 4
// row address into every memory
`define MM_AWIDTH 2
// rows held per memory
`define MM_DEPTH 4

//////////////////////////////
// sequencer phases, in cycles
//////////////////////////////

`define MM_FETCH_LEN 4
// skew + array depth + one memory read, with a spare cycle
`define MM_DRAIN_LEN 8
`define MM_WRITE_LEN 4
// wide enough for the longest phase
`define MM_TWIDTH 4

`endif

// ==== logic/matmul_pkg.sv ====
`default_nettype none
`include "matmul_config.svh"

package matmul_pkg;

  // one operand or result element
  typedef logic [`MM_DWIDTH-1:0] elem_t;
  // one memory row, element 0 in the low bits
  typedef elem_t [`MM_DIM-1:0] vec_t;
  // full precision sum of products
  typedef logic [2*`MM_DWIDTH-1:0] acc_t;
  // indexed [row][col]
  typedef acc_t [`MM_DIM-1:0][`MM_DIM-1:0] acc_matrix_t;
  typedef logic [`MM_AWIDTH-1:0] row_addr_t;

  typedef enum logic [1:0] {IDLE, FETCH, DRAIN, WRITE} seq_state_e;
  // load opcode, which operand memory takes the row
  typedef enum logic {SEL_A, SEL_B} matrix_sel_e;

endpackage

// skewed operand stream into the array
interface feed_if;
  import matmul_pkg::*;
  vec_t a_col;
  vec_t b_row;
  logic clear;
  logic active;
  modport feeder (output a_col, output b_row, output clear, output active);
  modport array (input a_col, input b_row, input clear, input active);
endinterface

`default_nettype wire

// ==== logic/operand_ram.sv ====
`default_nettype none
`include "matmul_config.svh"

module operand_ram (
  input  logic                  clk,
  input  logic                  wr_en,
  input  matmul_pkg::row_addr_t wr_addr,
  input  matmul_pkg::vec_t      wr_data,
  input  matmul_pkg::row_addr_t rd_addr,
  output matmul_pkg::vec_t      rd_data
);
  import matmul_pkg::*;

  // one row per address
  // A keeps a column of A per row, B keeps a row of B
  vec_t mem [`MM_DEPTH];

  //////////////////////////////
  // write port
  //////////////////////////////

  // enable comes already qualified by the load handshake
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // registered read, data one cycle after the address
  // reads every cycle, the feeder decides what is valid
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== logic/phase_timer.sv ====
`default_nettype none
`include "matmul_config.svh"

module phase_timer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load,
  input  logic [`MM_TWIDTH-1:0]  length,
  output matmul_pkg::row_addr_t  count,
  output logic                   last
);
  import matmul_pkg::*;

  logic [`MM_TWIDTH-1:0] cnt;
  logic [`MM_TWIDTH-1:0] last_idx;
  logic                  running;

  // load wins over the end of the current phase
  // so phases run back to back with no gap
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt      <= '0;
      last_idx <= '0;
      running  <= 1'b0;
    end else if (load) begin
      cnt      <= '0;
      last_idx <= length - 1'b1;
      running  <= 1'b1;
    end else if (running) begin
      if (last) begin
        // no reload, go idle
        running <= 1'b0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  assign last = running && (cnt == last_idx);
  // low bits double as fetch and write-back row
  assign count = cnt[`MM_AWIDTH-1:0];

endmodule

`default_nettype wire

// ==== logic/mul_sequencer.sv ====
`default_nettype none
`include "matmul_config.svh"

module mul_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load_valid,
  output logic                      load_ready,
  input  matmul_pkg::matrix_sel_e   load_sel,
  input  logic                      start_valid,
  output logic                      start_ready,
  output logic                      done,
  output logic                      a_wr_en,
  output logic                      b_wr_en,
  output logic                      timer_load,
  output logic [`MM_TWIDTH-1:0]     timer_length,
  input  logic                      timer_last,
  input  matmul_pkg::row_addr_t     timer_count,
  output logic                      fetch,
  output logic                      clear_acc,
  output matmul_pkg::row_addr_t     fetch_addr,
  output logic                      wb_en,
  output matmul_pkg::row_addr_t     wb_row
);
  import matmul_pkg::*;

  localparam int busy_cycles = `MM_FETCH_LEN + `MM_DRAIN_LEN + `MM_WRITE_LEN;

  seq_state_e state;
  seq_state_e state_next;
  logic       load_acc;
  logic       start_acc;

  //////////////////////////////
  // host handshakes
  //////////////////////////////

  // host channels only open while idle
  assign load_ready  = (state == IDLE);
  assign start_ready = (state == IDLE);
  assign load_acc    = load_valid && load_ready;
  assign start_acc   = start_valid && start_ready;
  // opcode picks the operand memory
  assign a_wr_en     = load_acc && (load_sel == SEL_A);
  assign b_wr_en     = load_acc && (load_sel == SEL_B);

  //////////////////////////////
  // phase FSM
  //////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      IDLE:  if (start_acc) state_next = FETCH;
      FETCH: if (timer_last) state_next = DRAIN;
      DRAIN: if (timer_last) state_next = WRITE;
      WRITE: if (timer_last) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // timer reloads one cycle ahead of each phase
  assign timer_load = start_acc || (timer_last && (state == FETCH || state == DRAIN));

  // length of the phase that comes next
  always_comb begin
    case (state)
      FETCH:   timer_length = `MM_TWIDTH'(`MM_DRAIN_LEN);
      DRAIN:   timer_length = `MM_TWIDTH'(`MM_WRITE_LEN);
      default: timer_length = `MM_TWIDTH'(`MM_FETCH_LEN);
    endcase
  end

  assign fetch      = (state == FETCH);
  assign fetch_addr = timer_count;
  // feeder delays this to land just before the first product
  assign clear_acc  = start_acc;
  assign wb_en      = (state == WRITE);
  assign wb_row     = timer_count;
  // same cycle as the last row write
  assign done       = (state == WRITE) && timer_last;

  // busy for the whole fixed sequence until done
  ap_busy_window: assert property (@(posedge clk) disable iff (reset)
    start_acc |=> (!load_ready && !start_ready && !done) [*(busy_cycles - 1)] ##1 done);

  // done marks the write of the last C row
  ap_done_last_row: assert property (@(posedge clk) disable iff (reset)
    done |-> wb_row == row_addr_t'(`MM_DIM - 1));

endmodule

`default_nettype wire

// ==== logic/skew_feeder.sv ====
`default_nettype none
`include "matmul_config.svh"

module skew_feeder (
  input  logic             clk,
  input  logic             reset,
  input  logic             fetch,
  input  logic             clear_acc,
  input  matmul_pkg::vec_t a_rows,
  input  matmul_pkg::vec_t b_rows,
  feed_if.feeder           feed
);
  import matmul_pkg::*;

  logic  valid_q;
  logic  clear_q;
  vec_t  a_in;
  vec_t  b_in;
  elem_t a_out [`MM_DIM];
  elem_t b_out [`MM_DIM];

  // line up with the registered memory read
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      valid_q <= fetch;
      clear_q <= clear_acc;
    end
  end

  // zero fill outside the fetch window
  assign a_in = valid_q ? a_rows : '0;
  assign b_in = valid_q ? b_rows : '0;

  //////////////////////////////
  // per lane skew, lane i waits i cycles
  //////////////////////////////

  for (genvar i = 0; i < `MM_DIM; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign a_out[i] = a_in[i];
      assign b_out[i] = b_in[i];
    end else begin : g_delay
      elem_t a_sr [i];
      elem_t b_sr [i];
      always_ff @(posedge clk) begin
        a_sr[0] <= a_in[i];
        b_sr[0] <= b_in[i];
        for (int s = 1; s < i; s++) begin
          a_sr[s] <= a_sr[s-1];
          b_sr[s] <= b_sr[s-1];
        end
      end
      assign a_out[i] = a_sr[i-1];
      assign b_out[i] = b_sr[i-1];
    end
  end

  always_comb begin
    for (int i = 0; i < `MM_DIM; i++) begin
      feed.a_col[i] = a_out[i];
      feed.b_row[i] = b_out[i];
    end
  end

  assign feed.clear  = clear_q;
  assign feed.active = valid_q;

endmodule

`default_nettype wire

// ==== logic/pe_array.sv ====
`default_nettype none
`include "matmul_config.svh"

module pe_array (
  input  logic                    clk,
  input  logic                    reset,
  feed_if.array                   feed,
  output matmul_pkg::acc_matrix_t acc
);
  import matmul_pkg::*;

  // pass-through registers, a moves right, b moves down
  elem_t a_q   [`MM_DIM][`MM_DIM];
  elem_t b_q   [`MM_DIM][`MM_DIM];
  acc_t  acc_q [`MM_DIM][`MM_DIM];

  //////////////////////////////
  // MAC grid
  //////////////////////////////

  for (genvar i = 0; i < `MM_DIM; i++) begin : g_row
    for (genvar j = 0; j < `MM_DIM; j++) begin : g_col
      elem_t a_in;
      elem_t b_in;
      acc_t  prod;

      // left column takes the skewed A lane
      if (j == 0) begin : g_a_edge
        assign a_in = feed.a_col[i];
      end else begin : g_a_pass
        assign a_in = a_q[i][j-1];
      end

      // top row takes the skewed B lane
      if (i == 0) begin : g_b_edge
        assign b_in = feed.b_row[j];
      end else begin : g_b_pass
        assign b_in = b_q[i-1][j];
      end

      // full 32 bit product
      assign prod = a_in * b_in;

      // zeros outside the window keep the sum unchanged
      always_ff @(posedge clk) begin
        if (reset) begin
          a_q[i][j]   <= '0;
          b_q[i][j]   <= '0;
          acc_q[i][j] <= '0;
        end else begin
          a_q[i][j] <= a_in;
          b_q[i][j] <= b_in;
          if (feed.clear) begin
            acc_q[i][j] <= '0;
          end else begin
            acc_q[i][j] <= acc_q[i][j] + prod;
          end
        end
      end
    end
  end

  // pack for the result store
  always_comb begin
    for (int i = 0; i < `MM_DIM; i++) begin
      for (int j = 0; j < `MM_DIM; j++) begin
        acc[i][j] = acc_q[i][j];
      end
    end
  end

  // a clear during a live step would drop a product
  ap_clear_idle: assert property (@(posedge clk) disable iff (reset)
    !(feed.clear && feed.active));

endmodule

`default_nettype wire

// ==== logic/result_store.sv ====
`default_nettype none
`include "matmul_config.svh"

module result_store (
  input  logic                    clk,
  input  logic                    wb_en,
  input  matmul_pkg::row_addr_t   wb_row,
  input  matmul_pkg::acc_matrix_t acc,
  input  logic                    rd_en,
  input  matmul_pkg::row_addr_t   rd_addr,
  output matmul_pkg::vec_t        rd_data
);
  import matmul_pkg::*;

  // matrix C, one row per address
  vec_t c_mem [`MM_DEPTH];
  vec_t sat_row;

  //////////////////////////////
  // precision reduction
  //////////////////////////////

  // anything past 16 bits clamps to all ones
  always_comb begin
    for (int j = 0; j < `MM_DIM; j++) begin
      if (|acc[wb_row][j][2*`MM_DWIDTH-1:`MM_DWIDTH]) begin
        sat_row[j] = '1;
      end else begin
        sat_row[j] = acc[wb_row][j][`MM_DWIDTH-1:0];
      end
    end
  end

  //////////////////////////////
  // C memory
  //////////////////////////////

  // one row per cycle during write-back
  always_ff @(posedge clk) begin
    if (wb_en) begin
      c_mem[wb_row] <= sat_row;
    end
  end

  // host read, valid the next cycle
  // holds the last row read when idle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= c_mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== logic/matmul_top.sv ====
`default_nettype none
`include "matmul_config.svh"

module matmul_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    load_valid,
  output logic                    load_ready,
  input  matmul_pkg::matrix_sel_e load_sel,
  input  matmul_pkg::row_addr_t   load_addr,
  input  matmul_pkg::vec_t        load_data,
  input  logic                    start_valid,
  output logic                    start_ready,
  output logic                    done,
  input  logic                    rd_en,
  input  matmul_pkg::row_addr_t   rd_addr,
  output matmul_pkg::vec_t        rd_data
);
  import matmul_pkg::*;

  // sequencer control
  logic                  a_wr_en;
  logic                  b_wr_en;
  logic                  timer_load;
  logic [`MM_TWIDTH-1:0] timer_length;
  logic                  timer_last;
  row_addr_t             timer_count;
  logic                  fetch;
  logic                  clear_acc;
  row_addr_t             fetch_addr;
  logic                  wb_en;
  row_addr_t             wb_row;
  // datapath
  vec_t                  a_rows;
  vec_t                  b_rows;
  acc_matrix_t           acc;

  feed_if feed_bus ();

  mul_sequencer mul_sequencer_i (
    .clk(clk), .reset(reset),
    .load_valid(load_valid), .load_ready(load_ready), .load_sel(load_sel),
    .start_valid(start_valid), .start_ready(start_ready), .done(done),
    .a_wr_en(a_wr_en), .b_wr_en(b_wr_en),
    .timer_load(timer_load), .timer_length(timer_length),
    .timer_last(timer_last), .timer_count(timer_count),
    .fetch(fetch), .clear_acc(clear_acc), .fetch_addr(fetch_addr),
    .wb_en(wb_en), .wb_row(wb_row)
  );

  phase_timer phase_timer_i (
    .clk(clk), .reset(reset), .load(timer_load), .length(timer_length),
    .count(timer_count), .last(timer_last)
  );

  // A columns and B rows share load address and data
  operand_ram a_ram_i (
    .clk(clk), .wr_en(a_wr_en), .wr_addr(load_addr), .wr_data(load_data),
    .rd_addr(fetch_addr), .rd_data(a_rows)
  );

  operand_ram b_ram_i (
    .clk(clk), .wr_en(b_wr_en), .wr_addr(load_addr), .wr_data(load_data),
    .rd_addr(fetch_addr), .rd_data(b_rows)
  );

  skew_feeder skew_feeder_i (
    .clk(clk), .reset(reset), .fetch(fetch), .clear_acc(clear_acc),
    .a_rows(a_rows), .b_rows(b_rows), .feed(feed_bus.feeder)
  );

  pe_array pe_array_i (
    .clk(clk), .reset(reset), .feed(feed_bus.array), .acc(acc)
  );

  result_store result_store_i (
    .clk(clk), .wb_en(wb_en), .wb_row(wb_row), .acc(acc),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
  );

endmodule

`default_nettype wire

// ==== verif/matmul_tb.sv ====
`default_nettype none
`include "matmul_config.svh"

module matmul_tb;
  import matmul_pkg::*;

  // busy window of one multiply
  localparam int run_cycles = `MM_FETCH_LEN + `MM_DRAIN_LEN + `MM_WRITE_LEN;
  // A and B loads, C reads, handshake slack
  localparam int host_cycles = 3 * `MM_DIM + 4;
  // 20 multiplies, 10 time units per cycle
  localparam int watchdog_time = 10 * (20 * (run_cycles + host_cycles) + 3);

  logic        clk;
  logic        reset;
  logic        load_valid;
  logic        load_ready;
  matrix_sel_e load_sel;
  row_addr_t   load_addr;
  vec_t        load_data;
  logic        start_valid;
  logic        start_ready;
  logic        done;
  logic        rd_en;
  row_addr_t   rd_addr;
  vec_t        rd_data;

  // operands and expected result, [row][col]
  elem_t       a_m   [`MM_DIM][`MM_DIM];
  elem_t       b_m   [`MM_DIM][`MM_DIM];
  elem_t       c_ref [`MM_DIM][`MM_DIM];
  integer      seed;
  vec_t        exp_row;
  // host-side view of the busy window
  int          busy_cnt;
  logic        chk_q;
  vec_t        exp_q;
  row_addr_t   addr_q;

  matmul_top matmul_top_i (
    .clk(clk), .reset(reset),
    .load_valid(load_valid), .load_ready(load_ready), .load_sel(load_sel),
    .load_addr(load_addr), .load_data(load_data),
    .start_valid(start_valid), .start_ready(start_ready), .done(done),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////
  // checkers
  //////////////////////////////

  task automatic report_and_stop(input string msg);
    $display("FAIL %0t %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "check failed");
  endtask

  // counts down from start acceptance, 1 on the last WRITE cycle
  always @(posedge clk) begin
    if (reset) begin
      busy_cnt <= 0;
      chk_q    <= 1'b0;
    end else begin
      if (busy_cnt == 0 && start_valid && start_ready) begin
        busy_cnt <= run_cycles;
      end else if (busy_cnt != 0) begin
        busy_cnt <= busy_cnt - 1;
      end
      chk_q <= rd_en;
    end
    // read expectation, one cycle behind the request
    exp_q  <= exp_row;
    addr_q <= rd_addr;
  end

  // open channels and no done while idle
  ap_idle_open: assert property (@(posedge clk) disable iff (reset)
    busy_cnt == 0 |-> load_ready && start_ready && !done)
    else report_and_stop("host channels not open while idle");

  // back-pressure for the whole sequence
  ap_busy_closed: assert property (@(posedge clk) disable iff (reset)
    busy_cnt != 0 |-> !load_ready && !start_ready)
    else report_and_stop("ready high while a multiply runs");

  // exactly one done per start, on the last cycle
  ap_done_at_end: assert property (@(posedge clk) disable iff (reset)
    busy_cnt == 1 |-> done)
    else report_and_stop("done missing at the end of the sequence");

  ap_done_only_end: assert property (@(posedge clk) disable iff (reset)
    done |-> busy_cnt == 1)
    else report_and_stop("done outside the last write-back cycle");

  ap_read_data: assert property (@(posedge clk) disable iff (reset)
    chk_q |-> rd_data == exp_q)
    else report_and_stop($sformatf("C row %0d read %h expected %h",
      $sampled(addr_q), $sampled(rd_data), $sampled(exp_q)));

  //////////////////////////////
  // reference model
  //////////////////////////////

  // C = A x B at full width, clamp past 16 bits
  task automatic compute_reference();
    logic [63:0] sum;
    for (int i = 0; i < `MM_DIM; i++) begin
      for (int j = 0; j < `MM_DIM; j++) begin
        sum = '0;
        for (int k = 0; k < `MM_DIM; k++) begin
          sum = sum + 64'(a_m[i][k]) * 64'(b_m[k][j]);
        end
        c_ref[i][j] = (sum > 64'hffff) ? 16'hffff : sum[15:0];
      end
    end
  endtask

  //////////////////////////////
  // operand patterns
  //////////////////////////////

  task automatic fill_identity_a();
    logic [31:0] r;
    for (int i = 0; i < `MM_DIM; i++) begin
      for (int k = 0; k < `MM_DIM; k++) begin
        r = $random(seed);
        a_m[i][k] = (i == k) ? 16'd1 : 16'd0;
        // full range B, passes straight through
        b_m[i][k] = r[15:0];
      end
    end
  endtask

  task automatic fill_small();
    logic [31:0] r;
    for (int i = 0; i < `MM_DIM; i++) begin
      for (int k = 0; k < `MM_DIM; k++) begin
        r = $random(seed);
        a_m[i][k] = {8'h00, r[7:0]};
        b_m[i][k] = {8'h00, r[15:8]};
      end
    end
  endtask

  // A near full scale, B near full scale or zero
  task automatic fill_near_max();
    logic [31:0] r;
    for (int i = 0; i < `MM_DIM; i++) begin
      for (int k = 0; k < `MM_DIM; k++) begin
        r = $random(seed);
        a_m[i][k] = {8'hff, r[7:0]};
        b_m[i][k] = r[16] ? {8'hff, r[15:8]} : 16'd0;
      end
    end
    // last C column stays unsaturated
    for (int k = 0; k < `MM_DIM; k++) begin
      b_m[k][`MM_DIM-1] = 16'd0;
    end
  endtask

  //////////////////////////////
  // host side
  //////////////////////////////

  // A column k and B row k share address k
  task automatic load_operands();
    vec_t col;
    vec_t row;
    for (int k = 0; k < `MM_DIM; k++) begin
      for (int i = 0; i < `MM_DIM; i++) begin
        col[i] = a_m[i][k];
        row[i] = b_m[k][i];
      end
      @(negedge clk);
      load_valid = 1'b1;
      load_sel   = SEL_A;
      load_addr  = row_addr_t'(k);
      load_data  = col;
      @(negedge clk);
      load_sel   = SEL_B;
      load_data  = row;
    end
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  // start, then wait for done
  // optional load attempts while busy must be held off
  task automatic run_multiply(input bit poke_load);
    int cycles;
    cycles = 0;
    @(negedge clk);
    start_valid = 1'b1;
    @(negedge clk);
    start_valid = 1'b0;
    while (!done) begin
      if (poke_load) begin
        load_valid = (cycles >= 2) && (cycles < 10);
        load_sel   = SEL_A;
        load_addr  = '0;
        load_data  = {`MM_DIM{16'hdead}};
      end
      @(negedge clk);
      cycles++;
    end
    load_valid = 1'b0;
  endtask

  task automatic read_and_check();
    vec_t row;
    for (int r = 0; r < `MM_DIM; r++) begin
      for (int j = 0; j < `MM_DIM; j++) begin
        row[j] = c_ref[r][j];
      end
      @(negedge clk);
      rd_en   = 1'b1;
      rd_addr = row_addr_t'(r);
      exp_row = row;
    end
    @(negedge clk);
    rd_en = 1'b0;
  endtask

  task automatic multiply_and_check(input bit reload, input bit poke_load);
    if (reload) begin
      load_operands();
      compute_reference();
    end
    run_multiply(poke_load);
    read_and_check();
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    seed        = 32'ha0e7_4b8e;
    reset       = 1'b1;
    load_valid  = 1'b0;
    load_sel    = SEL_A;
    load_addr   = '0;
    load_data   = '0;
    start_valid = 1'b0;
    rd_en       = 1'b0;
    rd_addr     = '0;
    exp_row     = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // idle a few cycles, ready and done watched
    repeat (4) @(negedge clk);

    // identity A, C equals B
    fill_identity_a();
    multiply_and_check(1'b1, 1'b0);

    // small random operands
    repeat (4) begin
      fill_small();
      multiply_and_check(1'b1, 1'b0);
    end

    // saturation
    repeat (3) begin
      fill_near_max();
      multiply_and_check(1'b1, 1'b0);
    end

    // rerun without reload, accumulators must clear
    fill_small();
    multiply_and_check(1'b1, 1'b1);
    multiply_and_check(1'b0, 1'b0);

    $display("Simulation passed");
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_time);
    $display("watchdog expired before the test sequence finished");
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
logic/matmul_pkg.sv
logic/operand_ram.sv
logic/phase_timer.sv
logic/mul_sequencer.sv
logic/skew_feeder.sv
logic/pe_array.sv
logic/result_store.sv
logic/matmul_top.sv
verif/matmul_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := matmul_tb
FILELIST  := list.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
